// ==== build.f ====
common/memPkg.sv
ram/ram.sv
verilog/memArbiter.sv
verilog/latencyRegs.sv
verilog/memSubsystem.sv
dv/memChecker.sv
dv/memSubsystemTb.sv

// ==== common/memPkg.sv ====
// shared types for the CPU memory subsystem
// every RTL block takes what it needs from here by wildcard import
// request structs carry enables, address and store data as one bundle
package memPkg;

   // data and address word
   typedef logic [31:0] word_t;

   // width of the latency field in the configuration block
   localparam int LAT_WIDTH = 4;

   // marker shown on the load bus whenever no access is in progress
   localparam logic [31:0] BAD_WORD = 32'hBAD1BAD1;

   // status reported by the RAM every cycle
   typedef enum logic [1:0] {FREE, BUSY, ACCESS, ERROR} ramState_t;

   // arbiter grant lock
   typedef enum logic [1:0] {IDLE, IGRANT, DGRANT} arbState_t;

   // request from the arbiter to the RAM, byte address
   typedef struct packed {
      logic  ren;
      logic  wen;
      word_t addr;
      word_t store;
   } memReq_t;

   // instruction fetch port, read only
   typedef struct packed {
      logic  iren;
      word_t iaddr;
   } instPort_t;

   // data port, loads and stores
   typedef struct packed {
      logic  dren;
      logic  dwen;
      word_t daddr;
      word_t dstore;
   } dataPort_t;

   // configuration strobe access, sel picks latency, status or count
   typedef struct packed {
      logic       write;
      logic       read;
      logic [1:0] sel;
      word_t      wdata;
   } cfgReq_t;

endpackage

// ==== dv/memChecker.sv ====
// watches the memory subsystem ports and compares them with expected values
// the testbench raises cmpValid with a select, sampled at the falling edge
// completion cycle and load word of each port are captured as they happen
// prints a line per finished test and the counts at the end of the run
module memChecker
   import memPkg::*;
(
   input  logic         CLK,
   input  logic         nRST,
   input  instPort_t    inst,
   input  dataPort_t    data,
   input  logic         iWait,
   input  logic         dWait,
   input  word_t        iLoad,
   input  word_t        dLoad,
   input  word_t        cfgRdata,
   input  ramState_t    ramState,
   input  logic [191:0] testName,
   input  logic         cmpValid,
   input  logic [2:0]   cmpSel,
   input  word_t        expected,
   input  logic         testDone,
   input  logic         runDone,
   output int           failCount
);

   // compare selects, same codes as the testbench
   localparam logic [2:0] SEL_CFG   = 3'd0;
   localparam logic [2:0] SEL_DLOAD = 3'd1;
   localparam logic [2:0] SEL_ILOAD = 3'd2;
   localparam logic [2:0] SEL_DLAT  = 3'd3;
   localparam logic [2:0] SEL_ILAT  = 3'd4;
   localparam logic [2:0] SEL_STATE = 3'd5;
   localparam logic [2:0] SEL_DWAIT = 3'd6;

   logic  dActive;
   logic  iActive;
   int    dCycles;
   int    iCycles;
   // what each port saw in its completion cycle
   word_t dLat;
   word_t iLat;
   word_t dVal;
   word_t iVal;
   word_t actual;
   int    testFails;
   int    testCount;
   int    passCount;

   initial
   begin
      dActive   = 1'b0;
      iActive   = 1'b0;
      dCycles   = 0;
      iCycles   = 0;
      dLat      = '0;
      iLat      = '0;
      dVal      = '0;
      iVal      = '0;
      testFails = 0;
      testCount = 0;
      passCount = 0;
      failCount = 0;
   end

   always @(negedge CLK)
   begin
      if (nRST)
      begin
         // a port that asks for nothing must never stall
         if (!inst.iren && iWait)
         begin
            $display("error in %0s: fetch wait high with no fetch request", testName);
            testFails++;
         end
         if (!(data.dren || data.dwen) && dWait)
         begin
            $display("error in %0s: data wait high with no data request", testName);
            testFails++;
         end
         // data port, cycles counted from the first cycle of the request
         if (data.dren || data.dwen)
         begin
            dCycles = dActive ? dCycles + 1 : 0;
            dActive = 1'b1;
            if (!dWait)
            begin
               dLat    = dCycles;
               dVal    = dLoad;
               dActive = 1'b0;
            end
         end
         else
         begin
            dActive = 1'b0;
         end
         // fetch port, same scheme
         if (inst.iren)
         begin
            iCycles = iActive ? iCycles + 1 : 0;
            iActive = 1'b1;
            if (!iWait)
            begin
               iLat    = iCycles;
               iVal    = iLoad;
               iActive = 1'b0;
            end
         end
         else
         begin
            iActive = 1'b0;
         end
         if (cmpValid)
         begin
            case (cmpSel)
               SEL_CFG:   actual = cfgRdata;
               SEL_DLOAD: actual = dVal;
               SEL_ILOAD: actual = iVal;
               SEL_DLAT:  actual = dLat;
               SEL_ILAT:  actual = iLat;
               SEL_STATE: actual = 32'(ramState);
               SEL_DWAIT: actual = {31'b0, dWait};
               default:   actual = 'x;
            endcase
            if (actual !== expected)
            begin
               $display("CHECK FAILED %0s: expected %h, actual %h", testName, expected, actual);
               testFails++;
            end
         end
         if (testDone)
         begin
            testCount++;
            if (testFails == 0)
            begin
               passCount++;
               $display("test %0s passed", testName);
            end
            else
            begin
               $display("test %0s failed with %0d errors", testName, testFails);
            end
            failCount = failCount + testFails;
            testFails = 0;
         end
         if (runDone)
         begin
            // errors outside any test still count
            failCount = failCount + testFails;
            testFails = 0;
            $display("tests %0d, passed %0d, failed %0d, errors %0d",
                     testCount, passCount, testCount - passCount, failCount);
         end
      end
   end

endmodule

// ==== dv/memInput.txt ====
# columns: name op addr data addr2 expected, op in decimal, the rest in hex
# op 0 cfg write, 1 cfg read, 2 data write, 3 data read, 4 fetch, 5 both, 6 error pair
# config ops use addr as sel, op 5 uses data as the expected dLoad
rstLat      1 00000000 00000000 00000000 00000002
rstStatus   1 00000001 00000000 00000000 00000000
rstCount    1 00000002 00000000 00000000 00000000
wrL2        2 00000008 12345678 00000000 00000000
rdL2        3 00000008 00000000 00000000 12345678
lat0        0 00000000 00000000 00000000 00000000
lat0Rd      1 00000000 00000000 00000000 00000000
wrA0        2 00000010 11112222 00000000 00000000
rdA0        3 00000010 00000000 00000000 11112222
wrB0        2 00000014 33334444 00000000 00000000
rdB0        3 00000014 00000000 00000000 33334444
fetchA0     4 00000010 00000000 00000000 11112222
bothL0      5 00000014 33334444 00000010 11112222
cnt0        1 00000002 00000000 00000000 00000009
clrCount    0 00000002 00000000 00000000 00000000
cntClr      1 00000002 00000000 00000000 00000000
lat3        0 00000000 00000003 00000000 00000000
lat3Rd      1 00000000 00000000 00000000 00000003
wrC3        2 00000100 cafe0001 00000000 00000000
wrD3        2 00000104 cafe0002 00000000 00000000
rdC3        3 00000100 00000000 00000000 cafe0001
rdD3        3 00000104 00000000 00000000 cafe0002
fetchD3     4 00000104 00000000 00000000 cafe0002
fetchA3     4 00000010 00000000 00000000 11112222
bothL3      5 00000100 cafe0001 00000104 cafe0002
cnt3        1 00000002 00000000 00000000 00000008
errPair     6 00000100 deadbeef 00000000 00000000
errFlag     1 00000001 00000000 00000000 00000001
errClr      0 00000001 00000001 00000000 00000000
errFlagClr  1 00000001 00000000 00000000 00000000
errKeep     3 00000100 00000000 00000000 cafe0001
lat1        0 00000000 00000001 00000000 00000000
wrF1        2 00000200 a5a5a5a5 00000000 00000000
bothL1      5 00000200 a5a5a5a5 00000014 33334444
rdF1        3 00000200 00000000 00000000 a5a5a5a5
lat2        0 00000000 00000002 00000000 00000000
lat2Rd      1 00000000 00000000 00000000 00000002
wrE2        2 00000ffc 0badf00d 00000000 00000000
fetchE2     4 00000ffc 00000000 00000000 0badf00d
bothL2      5 00000ffc 0badf00d 00000010 11112222
cntEnd      1 00000002 00000000 00000000 00000011

// ==== dv/memSubsystemTb.sv ====
// top of the memory subsystem testbench
// reads one operation per line from dv/memInput.txt and drives it into the DUT
// inputs change 10 time units after the rising edge and are held until wait drops
// memChecker beside the DUT samples mid-cycle and keeps the error counts
module memSubsystemTb
   import memPkg::*;
();

   localparam int MEM_WORDS  = 1024;
   localparam int RESET_LAT  = 2;
   localparam int WAIT_LIMIT = 64;

   // operation codes of the stimulus file
   localparam int OP_CFG_WR  = 0;
   localparam int OP_CFG_RD  = 1;
   localparam int OP_DATA_WR = 2;
   localparam int OP_DATA_RD = 3;
   localparam int OP_FETCH   = 4;
   localparam int OP_BOTH    = 5;
   localparam int OP_ERROR   = 6;

   // compare selects understood by the checker
   localparam logic [2:0] SEL_CFG   = 3'd0;
   localparam logic [2:0] SEL_DLOAD = 3'd1;
   localparam logic [2:0] SEL_ILOAD = 3'd2;
   localparam logic [2:0] SEL_DLAT  = 3'd3;
   localparam logic [2:0] SEL_ILAT  = 3'd4;
   localparam logic [2:0] SEL_STATE = 3'd5;
   localparam logic [2:0] SEL_DWAIT = 3'd6;

   logic         CLK;
   logic         nRST;
   instPort_t    inst;
   dataPort_t    data;
   cfgReq_t      cfg;
   logic         iWait;
   logic         dWait;
   word_t        iLoad;
   word_t        dLoad;
   word_t        cfgRdata;
   ramState_t    ramState;
   // checker side
   logic [191:0] testName;
   logic         cmpValid;
   logic [2:0]   cmpSel;
   word_t        expected;
   logic         testDone;
   logic         runDone;
   int           failCount;
   // latency the DUT should be running with
   word_t        curLat;
   int           tbErrors;
   logic         timedOut;

   memSubsystem #(
      .MEM_WORDS     (MEM_WORDS),
      .RESET_LATENCY (RESET_LAT)
   ) u_dut (
      .CLK      (CLK),
      .nRST     (nRST),
      .inst     (inst),
      .data     (data),
      .cfg      (cfg),
      .iWait    (iWait),
      .dWait    (dWait),
      .iLoad    (iLoad),
      .dLoad    (dLoad),
      .cfgRdata (cfgRdata),
      .ramState (ramState)
   );

   memChecker u_checker (
      .CLK       (CLK),
      .nRST      (nRST),
      .inst      (inst),
      .data      (data),
      .iWait     (iWait),
      .dWait     (dWait),
      .iLoad     (iLoad),
      .dLoad     (dLoad),
      .cfgRdata  (cfgRdata),
      .ramState  (ramState),
      .testName  (testName),
      .cmpValid  (cmpValid),
      .cmpSel    (cmpSel),
      .expected  (expected),
      .testDone  (testDone),
      .runDone   (runDone),
      .failCount (failCount)
   );

   initial
   begin
      CLK = 1'b0;
      forever #50 CLK = ~CLK;
   end

   // to the drive point of the next cycle
   task automatic nextCycle();
      @(posedge CLK);
      #10;
   endtask

   // one compare, the checker samples it at this cycle's falling edge
   task automatic compare(input logic [2:0] sel, input word_t exp);
      cmpSel   = sel;
      expected = exp;
      cmpValid = 1'b1;
      nextCycle();
      cmpValid = 1'b0;
   endtask

   // hold until the port's wait drops, bounded
   task automatic waitPort(input logic isData);
      int   n;
      logic done;
      n    = 0;
      done = 1'b0;
      while (!done && (n < WAIT_LIMIT))
      begin
         @(negedge CLK);
         done = isData ? !dWait : !iWait;
         n++;
      end
      if (!done)
      begin
         $display("timeout in %0s: %0s port still waiting after %0d cycles",
                  testName, isData ? "data" : "fetch", WAIT_LIMIT);
         tbErrors++;
         timedOut = 1'b1;
      end
      // requests drop at the drive point after completion
      nextCycle();
   endtask

   task automatic runOp(input int op, input word_t addr, input word_t wdata,
                        input word_t addr2, input word_t expVal);
      case (op)
         OP_CFG_WR:
         begin
            cfg.write = 1'b1;
            cfg.sel   = addr[1:0];
            cfg.wdata = wdata;
            nextCycle();
            cfg = '0;
            if (addr[1:0] == 2'd0)
            begin
               curLat = wdata;
            end
         end
         OP_CFG_RD:
         begin
            cfg.read = 1'b1;
            cfg.sel  = addr[1:0];
            compare(SEL_CFG, expVal);
            cfg = '0;
         end
         OP_DATA_WR, OP_DATA_RD:
         begin
            data.dwen   = (op == OP_DATA_WR);
            data.dren   = (op == OP_DATA_RD);
            data.daddr  = addr;
            data.dstore = wdata;
            waitPort(1'b1);
            data = '0;
            if (op == OP_DATA_RD)
            begin
               compare(SEL_DLOAD, expVal);
            end
            // lone request, wait low L cycles after it shows up
            compare(SEL_DLAT, curLat);
         end
         OP_FETCH:
         begin
            inst.iren  = 1'b1;
            inst.iaddr = addr;
            waitPort(1'b0);
            inst = '0;
            compare(SEL_ILOAD, expVal);
            compare(SEL_ILAT, curLat);
         end
         OP_BOTH:
         begin
            // data column holds the expected dLoad here
            data.dren  = 1'b1;
            data.daddr = addr;
            inst.iren  = 1'b1;
            inst.iaddr = addr2;
            waitPort(1'b1);
            data = '0;
            waitPort(1'b0);
            inst = '0;
            compare(SEL_DLOAD, wdata);
            compare(SEL_DLAT, curLat);
            compare(SEL_ILOAD, expVal);
            // data first after L, fetch one more cycle plus L after that
            compare(SEL_ILAT, 2 * curLat + 1);
         end
         OP_ERROR:
         begin
            data.dren   = 1'b1;
            data.dwen   = 1'b1;
            data.daddr  = addr;
            data.dstore = wdata;
            nextCycle();
            compare(SEL_STATE, 32'(ERROR));
            compare(SEL_DWAIT, 32'd1);
            data = '0;
         end
         default:
         begin
            $display("unknown operation %0d in record %0s", op, testName);
            tbErrors++;
         end
      endcase
      testDone = 1'b1;
      nextCycle();
      testDone = 1'b0;
      nextCycle();
   endtask

   initial
   begin
      int           fd;
      int           code;
      int           n;
      int           op;
      string        line;
      logic [191:0] nameBits;
      word_t        addr;
      word_t        wdata;
      word_t        addr2;
      word_t        expVal;
      inst     = '0;
      data     = '0;
      cfg      = '0;
      nRST     = 1'b0;
      testName = '0;
      cmpValid = 1'b0;
      cmpSel   = '0;
      expected = '0;
      testDone = 1'b0;
      runDone  = 1'b0;
      curLat   = RESET_LAT;
      tbErrors = 0;
      timedOut = 1'b0;
      repeat (4) @(posedge CLK);
      #10;
      nRST = 1'b1;
      nextCycle();
      fd = $fopen("dv/memInput.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the stimulus file dv/memInput.txt");
         tbErrors++;
      end
      else
      begin
         while (!$feof(fd) && !timedOut)
         begin
            code = $fgets(line, fd);
            // skip comment lines and anything that is not a full record
            if ((code > 0) && (line.len() > 0) && (line[0] != "#"))
            begin
               n = $sscanf(line, "%s %d %h %h %h %h", nameBits, op, addr, wdata, addr2,
                           expVal);
               if (n == 6)
               begin
                  testName = nameBits;
                  runOp(op, addr, wdata, addr2, expVal);
               end
            end
         end
         $fclose(fd);
      end
      runDone = 1'b1;
      nextCycle();
      runDone = 1'b0;
      nextCycle();
      if ((tbErrors != 0) || (failCount != 0))
      begin
         $display("TEST FAILED");
      end
      else
      begin
         $display("TEST OK");
      end
      $finish;
   end

endmodule

// ==== ram/ram.sv ====
// single-port word RAM with a run-time latency
// a request must be held unchanged for latency cycles before it is served
// state tells the arbiter and the config block what the RAM is doing
// load carries BAD_WORD in every state but ACCESS
module ram
   import memPkg::*;
#(
   parameter int MEM_WORDS = 1024
)
(
   input  logic                 CLK,
   input  logic                 nRST,
   input  memReq_t              req,
   input  logic [LAT_WIDTH-1:0] latency,
   output word_t                load,
   output ramState_t            state
);

   // word index bits, two low address bits are the byte offset
   localparam int IDX_W = $clog2(MEM_WORDS);

   word_t                mem [MEM_WORDS];
   logic [IDX_W-1:0]     wordIdx;
   word_t                lastAddr;
   logic [1:0]           lastEn;
   logic [1:0]           reqEn;
   logic [LAT_WIDTH-1:0] count;
   logic                 match;
   logic                 restart;
   logic                 memWrite;

   assign reqEn   = {req.ren, req.wen};
   assign wordIdx = req.addr[IDX_W+1:2];

   // same address and enables as the request being timed
   assign match = (req.addr == lastAddr) && (reqEn == lastEn);

   // new request, no request, or the previous one just finished
   assign restart = !match || (reqEn == 2'b00) || (state == ACCESS);

   // stability counter
   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         lastAddr <= '0;
         lastEn   <= 2'b00;
         count    <= '0;
      end
      else if (restart)
      begin
         lastAddr <= req.addr;
         // after an access, clear enables so a held request is timed again
         lastEn   <= (state == ACCESS) ? 2'b00 : reqEn;
         // the first cycle a request is seen counts as one
         count    <= LAT_WIDTH'(1);
      end
      else if (count < latency)
      begin
         count <= count + 1'b1;
      end
   end

   // state decode
   always_comb
   begin
      case (reqEn)
         2'b00:   state = FREE;
         2'b11:   state = ERROR;
         default:
         begin
            // zero latency serves in the cycle the request shows up
            if ((latency == '0) || (match && (count >= latency)))
            begin
               state = ACCESS;
            end
            else
            begin
               state = BUSY;
            end
         end
      endcase
   end

   assign memWrite = (state == ACCESS) && req.wen;

   // array write, no reset on the storage
   always_ff @(posedge CLK)
   begin
      if (memWrite)
      begin
         mem[wordIdx] <= req.store;
      end
   end

   // combinational read, marker otherwise
   assign load = (state == ACCESS) ? mem[wordIdx] : BAD_WORD;

   // a write with nonzero latency lands only for a request held from the cycle before
   assert property (@(posedge CLK) disable iff (!nRST)
      (memWrite && (latency != '0)) |-> ($past(req) == req));

   // a request held past its access is timed again from the start
   assert property (@(posedge CLK) disable iff (!nRST)
      ((state == ACCESS) && (latency != '0)) |=> ((state != ACCESS) || (latency == '0)));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# compiles the memory subsystem testbench with Verilator and runs it
# pass or fail is decided by the pass line in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module memSubsystemTb -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

simOut=$(./obj_dir/VmemSubsystemTb)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
   echo "simulation exited with status $simStatus"
   exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "TEST OK"; then
   exit 0
fi
echo "pass line not found in simulation output"
exit 1

// ==== verilog/latencyRegs.sv ====
// configuration and status block beside the RAM
// sel 0 latency, sel 1 sticky error flag, sel 2 completed access count
// reads are combinational while cfg.read is high
module latencyRegs
   import memPkg::*;
#(
   parameter int RESET_LATENCY = 0
)
(
   input  logic                 CLK,
   input  logic                 nRST,
   input  cfgReq_t              cfg,
   input  ramState_t            state,
   output logic [LAT_WIDTH-1:0] latency,
   output word_t                cfgRdata
);

   logic  errorFlag;
   word_t accessCount;
   logic  latWrite;

   assign latWrite = cfg.write && (cfg.sel == 2'd0);

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         latency     <= LAT_WIDTH'(RESET_LATENCY);
         errorFlag   <= 1'b0;
         accessCount <= '0;
      end
      else
      begin
         if (latWrite)
         begin
            latency <= cfg.wdata[LAT_WIDTH-1:0];
         end
         // a new error wins over a clear in the same cycle
         if (state == ERROR)
         begin
            errorFlag <= 1'b1;
         end
         else if (cfg.write && (cfg.sel == 2'd1) && cfg.wdata[0])
         begin
            errorFlag <= 1'b0;
         end
         // every ACCESS cycle releases the arbiter lock, one per request
         if (cfg.write && (cfg.sel == 2'd2))
         begin
            accessCount <= '0;
         end
         else if (state == ACCESS)
         begin
            accessCount <= accessCount + 1'b1;
         end
      end
   end

   // read mux
   always_comb
   begin
      cfgRdata = '0;
      if (cfg.read)
      begin
         case (cfg.sel)
            2'd0:    cfgRdata = {{(32 - LAT_WIDTH){1'b0}}, latency};
            2'd1:    cfgRdata = {31'b0, errorFlag};
            2'd2:    cfgRdata = accessCount;
            default: cfgRdata = '0;
         endcase
      end
   end

   // latency writes fit the field
   assert property (@(posedge CLK) disable iff (!nRST)
      latWrite |-> (cfg.wdata < (1 << LAT_WIDTH)));

endmodule

// ==== verilog/memArbiter.sv ====
// shares the RAM between instruction fetch and the data port
// data wins when both ask in the same idle cycle
// the grant is locked until the RAM reports ACCESS
// each requesting port sees wait high until its own access completes
module memArbiter
   import memPkg::*;
(
   input  logic      CLK,
   input  logic      nRST,
   input  instPort_t inst,
   input  dataPort_t data,
   input  word_t     load,
   input  ramState_t state,
   output memReq_t   req,
   output logic      iWait,
   output logic      dWait,
   output word_t     iLoad,
   output word_t     dLoad
);

   arbState_t arbState;
   arbState_t nextState;
   logic      dataReq;
   logic      dGrant;
   logic      iGrant;
   logic      done;

   assign dataReq = data.dren || data.dwen;
   assign done    = (state == ACCESS);

   // idle grants combinationally, locked states hold their port
   assign dGrant = (arbState == DGRANT) || ((arbState == IDLE) && dataReq);
   assign iGrant = (arbState == IGRANT) || ((arbState == IDLE) && !dataReq && inst.iren);

   // request mux toward the RAM
   always_comb
   begin
      req = '0;
      if (dGrant)
      begin
         req.ren   = data.dren;
         req.wen   = data.dwen;
         req.addr  = data.daddr;
         req.store = data.dstore;
      end
      else if (iGrant)
      begin
         // fetch never writes
         req.ren  = inst.iren;
         req.addr = inst.iaddr;
      end
   end

   // lock next state
   always_comb
   begin
      nextState = arbState;
      case (arbState)
         IDLE:
         begin
            if (dGrant && !done)
            begin
               nextState = DGRANT;
            end
            else if (iGrant && !done)
            begin
               nextState = IGRANT;
            end
         end
         // release on completion, or if the owner gives up
         DGRANT:  if (done || !dataReq) nextState = IDLE;
         IGRANT:  if (done || !inst.iren) nextState = IDLE;
         default: nextState = IDLE;
      endcase
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         arbState <= IDLE;
      end
      else
      begin
         arbState <= nextState;
      end
   end

   // wait drops only in the access cycle of the granted port
   assign dWait = dataReq && !(dGrant && done);
   assign iWait = inst.iren && !(iGrant && done);

   // load only reaches the port that owns the RAM
   assign dLoad = dGrant ? load : BAD_WORD;
   assign iLoad = iGrant ? load : BAD_WORD;

   // the owner of a busy RAM keeps it into the next cycle
   assert property (@(posedge CLK) disable iff (!nRST)
      (state == BUSY) |=> $stable({dGrant, iGrant}));

endmodule

// ==== verilog/memSubsystem.sv ====
// memory side of the teaching CPU
// arbiter in front of a variable-latency RAM, config block beside it
// requesters hold their enables until their wait drops
// parameters are set here and passed to the RAM and config block
module memSubsystem
   import memPkg::*;
#(
   parameter int MEM_WORDS     = 1024,
   parameter int RESET_LATENCY = 0
)
(
   input  logic      CLK,
   input  logic      nRST,
   input  instPort_t inst,
   input  dataPort_t data,
   input  cfgReq_t   cfg,
   output logic      iWait,
   output logic      dWait,
   output word_t     iLoad,
   output word_t     dLoad,
   output word_t     cfgRdata,
   output ramState_t ramState
);

   // arbiter to RAM
   memReq_t              ramReq;
   // RAM back to the arbiter
   word_t                ramLoad;
   // config block steering the RAM
   logic [LAT_WIDTH-1:0] latency;

   memArbiter u_arbiter (
      .CLK   (CLK),
      .nRST  (nRST),
      .inst  (inst),
      .data  (data),
      .load  (ramLoad),
      .state (ramState),
      .req   (ramReq),
      .iWait (iWait),
      .dWait (dWait),
      .iLoad (iLoad),
      .dLoad (dLoad)
   );

   ram #(
      .MEM_WORDS (MEM_WORDS)
   ) u_ram (
      .CLK     (CLK),
      .nRST    (nRST),
      .req     (ramReq),
      .latency (latency),
      .load    (ramLoad),
      .state   (ramState)
   );

   latencyRegs #(
      .RESET_LATENCY (RESET_LATENCY)
   ) u_latencyRegs (
      .CLK      (CLK),
      .nRST     (nRST),
      .cfg      (cfg),
      .state    (ramState),
      .latency  (latency),
      .cfgRdata (cfgRdata)
   );

endmodule
